/* hdl/core_pkg.sv */
package core_pkg;

    // ************************************************************************
    // Widths
    // ************************************************************************
    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int IMEM_AW = 8;

    // ************************************************************************
    // RV32I encodings, subset
    // ************************************************************************
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // SUB, and the arithmetic shifts left out here
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SLT    = 4'd7,
        ALU_PASS_B = 4'd8,
        ALU_NOP    = 4'd15
    } alu_op_t;

    // Decode to execute
    typedef struct packed {
        logic              valid;
        alu_op_t           alu_op;
        logic              src_imm;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
        logic              wen;
    } dec_t;

    // Result on its way to the register file
    typedef struct packed {
        logic              wen;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

/* hdl/instr_ram.sv */
`timescale 1ns/10ps

module instr_ram (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [core_pkg::IMEM_AW-1:0] addr,
    input  logic                         we,
    input  logic [core_pkg::IMEM_AW-1:0] waddr,
    input  logic [core_pkg::XLEN-1:0]    wdata,
    output logic [core_pkg::XLEN-1:0]    dout
);
    import core_pkg::*;

    logic [XLEN-1:0] mem [2**IMEM_AW];

    // Program load port, open during reset too
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Zero word is a no-op downstream
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else begin
            dout <= mem[addr];
        end
    end

    // Fetch must only ever see loaded words
    a_dout_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(dout)
    ) else $error("instr_ram: unknown fetch word at pc %0h", addr);

endmodule

/* hdl/decode.sv */
`timescale 1ns/10ps

module decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [core_pkg::XLEN-1:0]   instr,
    output logic [core_pkg::REG_AW-1:0] rs1_addr,
    output logic [core_pkg::REG_AW-1:0] rs2_addr,
    output core_pkg::dec_t              dec
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            supported;
    logic            src_imm_nxt;
    alu_op_t         op_nxt;
    logic [XLEN-1:0] imm_nxt;
    dec_t            dec_nxt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register file is read during this step
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        supported   = 1'b0;
        src_imm_nxt = 1'b0;
        op_nxt      = ALU_NOP;
        imm_nxt     = {{(XLEN-12){instr[31]}}, instr[31:20]};
        case (opcode)
            OPC_LUI: begin
                supported   = 1'b1;
                src_imm_nxt = 1'b1;
                op_nxt      = ALU_PASS_B;
                imm_nxt     = {instr[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                supported   = 1'b1;
                src_imm_nxt = 1'b1;
                case (funct3)
                    F3_ADD:  op_nxt = ALU_ADD;
                    F3_SLT:  op_nxt = ALU_SLT;
                    F3_XOR:  op_nxt = ALU_XOR;
                    F3_OR:   op_nxt = ALU_OR;
                    F3_AND:  op_nxt = ALU_AND;
                    F3_SLL:  op_nxt = ALU_SLL;
                    F3_SR:   op_nxt = ALU_SRL;
                    default: supported = 1'b0;
                endcase
                // Shift immediates carry a funct7, SRAI is not supported
                if ((funct3 == F3_SLL || funct3 == F3_SR) && funct7 != 7'b0) begin
                    supported = 1'b0;
                end
            end
            OPC_OP: begin
                supported = 1'b1;
                if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    op_nxt = ALU_SUB;
                end else if (funct7 == 7'b0) begin
                    case (funct3)
                        F3_ADD:  op_nxt = ALU_ADD;
                        F3_SLL:  op_nxt = ALU_SLL;
                        F3_SLT:  op_nxt = ALU_SLT;
                        F3_XOR:  op_nxt = ALU_XOR;
                        F3_SR:   op_nxt = ALU_SRL;
                        F3_OR:   op_nxt = ALU_OR;
                        F3_AND:  op_nxt = ALU_AND;
                        default: supported = 1'b0;
                    endcase
                end else begin
                    supported = 1'b0;
                end
            end
            default: supported = 1'b0;
        endcase

        dec_nxt.valid   = supported;
        dec_nxt.alu_op  = supported ? op_nxt : ALU_NOP;
        dec_nxt.src_imm = src_imm_nxt;
        dec_nxt.rs1     = instr[19:15];
        dec_nxt.rs2     = instr[24:20];
        dec_nxt.rd      = instr[11:7];
        dec_nxt.imm     = imm_nxt;
        // x0 destination never writes
        dec_nxt.wen     = supported && (instr[11:7] != '0);
    end

    always_ff @(posedge clk) begin
        dec <= dec_nxt;
        if (rst) begin
            dec.valid <= 1'b0;
            dec.wen   <= 1'b0;
        end
    end

    a_wen_valid: assert property (
        @(posedge clk) disable iff (rst)
        dec.wen |-> dec.valid
    ) else $error("decode: write enable on an invalid slot");

endmodule

/* hdl/regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [core_pkg::REG_AW-1:0] rs1_addr,
    input  logic [core_pkg::REG_AW-1:0] rs2_addr,
    input  core_pkg::wb_t               wb,
    output logic [core_pkg::XLEN-1:0]   rs1_data,
    output logic [core_pkg::XLEN-1:0]   rs2_data,
    output logic [core_pkg::XLEN-1:0]   x1
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];
    logic            wr_ok;

    assign wr_ok = wb.wen && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through so a read sees this cycle's write
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wr_ok && wb.rd == rs1_addr) begin
            rs1_data = wb.data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wr_ok && wb.rd == rs2_addr) begin
            rs2_data = wb.data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    assign x1 = regs[1];

endmodule

/* hdl/exec.sv */
`timescale 1ns/10ps

module exec (
    input  logic                      clk,
    input  logic                      rst,
    input  core_pkg::dec_t            dec,
    input  logic [core_pkg::XLEN-1:0] rs1_data,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    output core_pkg::wb_t             wb
);
    import core_pkg::*;

    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    wb_t             ex_q;
    wb_t             mem_q;

    // Newest producer wins
    function automatic logic [XLEN-1:0] fwd(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   rf_val,
        input wb_t               ex,
        input wb_t               mem
    );
        if (addr != '0 && ex.wen && ex.rd == addr) begin
            return ex.data;
        end else if (addr != '0 && mem.wen && mem.rd == addr) begin
            return mem.data;
        end
        return rf_val;
    endfunction

    // Operands read in the decode step, held alongside dec
    always_ff @(posedge clk) begin
        rs1_q <= rs1_data;
        rs2_q <= rs2_data;
    end

    // ************************************************************************
    // Operand select and ALU
    // ************************************************************************
    always_comb begin
        op_a  = fwd(dec.rs1, rs1_q, ex_q, mem_q);
        fwd_b = fwd(dec.rs2, rs2_q, ex_q, mem_q);
        op_b  = dec.src_imm ? dec.imm : fwd_b;
    end

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            ALU_NOP:    alu_res = '0;
            default:    alu_res = '0;
        endcase
    end

    // ************************************************************************
    // Execute and memory stage registers
    // ************************************************************************
    always_ff @(posedge clk) begin
        ex_q.rd    <= dec.rd;
        ex_q.data  <= alu_res;
        // No data memory yet, so the memory stage only delays
        mem_q.rd   <= ex_q.rd;
        mem_q.data <= ex_q.data;
        if (rst) begin
            ex_q.wen  <= 1'b0;
            mem_q.wen <= 1'b0;
        end else begin
            ex_q.wen  <= dec.valid & dec.wen;
            mem_q.wen <= ex_q.wen;
        end
    end

    assign wb = mem_q;

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        mem_q.wen |-> (mem_q.rd != '0)
    ) else $error("exec: write to x0 reached the register file port");

endmodule

/* hdl/core.sv */
`timescale 1ns/10ps

module core (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         prog_we,
    input  logic [core_pkg::IMEM_AW-1:0] prog_addr,
    input  logic [core_pkg::XLEN-1:0]    prog_data,
    output logic [core_pkg::XLEN-1:0]    test
);
    import core_pkg::*;

    logic [IMEM_AW-1:0] pc;
    logic [XLEN-1:0]    instr;
    logic [REG_AW-1:0]  rs1_addr;
    logic [REG_AW-1:0]  rs2_addr;
    logic [XLEN-1:0]    rs1_data;
    logic [XLEN-1:0]    rs2_data;
    dec_t               dec;
    wb_t                wb;

    // Word address, wraps at the end of the RAM
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    instr_ram instr_ram_instance (
        .clk   (clk),
        .rst   (rst),
        .addr  (pc),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .dout  (instr)
    );

    decode decode_instance (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .dec      (dec)
    );

    exec exec_instance (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    regfile regfile_instance (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .x1       (test)
    );

endmodule

/* tb/core_checker.sv */
`timescale 1ns/10ps

module core_checker (
    input  logic        clk,
    input  logic        start,
    input  logic [31:0] expected,
    input  int          budget,
    input  logic [31:0] test,
    output logic        done,
    output int          pass_count,
    output int          fail_count
);
    int   test_num;
    int   cycles;
    logic bad;

    initial begin
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_num   = 0;
    end

    // One run per start pulse, sampled on the falling edge
    always @(posedge start) begin
        done   = 1'b0;
        bad    = 1'b0;
        cycles = 0;
        @(negedge clk);
        // Cycle 0, nothing can have been written yet
        if (test !== 32'h0) begin
            $display("Error: test after reset expected %08h actual %08h", 32'h0, test);
            bad = 1'b1;
        end
        while (test !== expected && cycles < budget) begin
            @(negedge clk);
            cycles++;
        end
        if (test !== expected) begin
            $display("test %0d: x1 never reached the expected value %08h in %0d cycles",
                     test_num, expected, budget);
            bad = 1'b1;
        end else begin
            for (int i = 0; i < 8; i++) begin
                @(negedge clk);
                if (test !== expected) begin
                    $display("Error: test expected %08h actual %08h", expected, test);
                    bad = 1'b1;
                end
            end
        end
        if (bad) begin
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("test %0d %s", test_num, bad ? "FAILED" : "ok");
        test_num++;
        done = 1'b1;
    end

endmodule

/* tb/tb_core.sv */
`timescale 1ns/10ps

module tb_core;
    import core_pkg::*;

    localparam int NTESTS   = 9;
    localparam int PROG_LEN = 8;
    localparam int LOAD_LEN = 16;
    localparam int DONE_MAX = 200;

    logic               clk = 1'b0;
    logic               rst;
    logic               prog_we;
    logic [IMEM_AW-1:0] prog_addr;
    logic [XLEN-1:0]    prog_data;
    logic [XLEN-1:0]    test;
    logic               start;
    logic [31:0]        exp_x1;
    int                 budget_now;
    logic               done;
    int                 pass_count;
    int                 fail_count;

    logic [31:0] lfsr = 32'hdbc7;
    logic [31:0] prog [NTESTS][PROG_LEN];
    int          budget [NTESTS];
    logic [31:0] expect_x1 [NTESTS];
    logic [11:0] a, b, c, lo;
    logic [19:0] u;
    logic [4:0]  s1, s2;
    logic [31:0] va, vb, vc, vu;
    logic        hung;
    int          n;

    always #2 clk = ~clk;

    core dut0 (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .test      (test)
    );

    core_checker checker0 (
        .clk        (clk),
        .start      (start),
        .expected   (exp_x1),
        .budget     (budget_now),
        .test       (test),
        .done       (done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // ************************************************************************
    // Random bits and instruction encoding
    // ************************************************************************
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic write_word(input int addr, input logic [31:0] data);
        @(negedge clk);
        prog_we   = 1'b1;
        prog_addr = addr[IMEM_AW-1:0];
        prog_data = data;
    endtask

    initial begin
        rst        = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        start      = 1'b0;
        exp_x1     = '0;
        budget_now = 0;
        hung       = 1'b0;

        for (int t = 0; t < NTESTS; t++) begin
            budget[t] = 40;
            for (int i = 0; i < PROG_LEN; i++) begin
                prog[t][i] = 32'h0;
            end
        end

        // Immediates
        a = 12'(rand_bits(12));
        prog[0][0] = enc_i(F3_ADD, 5'd1, 5'd0, a);
        expect_x1[0] = sext12(a);
        u = 20'(rand_bits(20));
        prog[1][0] = enc_u(5'd1, u);
        expect_x1[1] = {u, 12'h0};

        // Back to back through the execute stage
        a = 12'(rand_bits(12));
        prog[2][0] = enc_i(F3_ADD, 5'd2, 5'd0, a);
        prog[2][1] = enc_r(7'd0, F3_ADD, 5'd1, 5'd2, 5'd2);
        prog[2][2] = enc_r(F7_ALT, F3_ADD, 5'd1, 5'd1, 5'd2);
        expect_x1[2] = sext12(a);

        // Distance two and three
        a = 12'(rand_bits(12));
        b = 12'(rand_bits(12));
        c = 12'(rand_bits(12));
        va = sext12(a);
        vb = sext12(b);
        vc = sext12(c);
        prog[3][0] = enc_i(F3_ADD, 5'd2, 5'd0, a);
        prog[3][1] = enc_i(F3_ADD, 5'd3, 5'd0, b);
        prog[3][2] = enc_i(F3_ADD, 5'd4, 5'd0, c);
        prog[3][3] = enc_r(7'd0, F3_AND, 5'd5, 5'd2, 5'd3);
        prog[3][4] = enc_r(7'd0, F3_XOR, 5'd6, 5'd4, 5'd2);
        prog[3][6] = enc_r(7'd0, F3_OR, 5'd1, 5'd5, 5'd6);
        expect_x1[3] = (va & vb) | (vc ^ va);

        a = 12'(rand_bits(12));
        b = 12'(rand_bits(12));
        va = sext12(a);
        vb = sext12(b);
        prog[4][0] = enc_i(F3_ADD, 5'd2, 5'd0, a);
        prog[4][1] = enc_i(F3_ADD, 5'd3, 5'd0, b);
        prog[4][3] = enc_r(7'd0, F3_SLT, 5'd4, 5'd2, 5'd3);
        prog[4][6] = enc_r(7'd0, F3_XOR, 5'd1, 5'd4, 5'd2);
        expect_x1[4] = {31'h0, $signed(va) < $signed(vb)} ^ va;

        // Shifts by register and by immediate
        u  = 20'(rand_bits(20));
        lo = 12'(rand_bits(12));
        a  = 12'(rand_bits(12));
        vu = {u, 12'h0} + sext12(lo);
        prog[5][0] = enc_u(5'd2, u);
        prog[5][1] = enc_i(F3_ADD, 5'd2, 5'd2, lo);
        prog[5][2] = enc_i(F3_ADD, 5'd3, 5'd0, a);
        prog[5][3] = enc_r(7'd0, F3_SLL, 5'd4, 5'd2, 5'd3);
        prog[5][4] = enc_r(7'd0, F3_SR, 5'd5, 5'd2, 5'd3);
        prog[5][5] = enc_r(F7_ALT, F3_ADD, 5'd1, 5'd4, 5'd5);
        expect_x1[5] = (vu << a[4:0]) - (vu >> a[4:0]);

        u  = 20'(rand_bits(20));
        lo = 12'(rand_bits(12));
        s1 = 5'(rand_bits(5));
        s2 = 5'(rand_bits(5));
        vu = {u, 12'h0} + sext12(lo);
        prog[6][0] = enc_u(5'd2, u);
        prog[6][1] = enc_i(F3_ADD, 5'd2, 5'd2, lo);
        prog[6][2] = enc_i(F3_SLL, 5'd4, 5'd2, {7'd0, s1});
        prog[6][3] = enc_i(F3_SR, 5'd5, 5'd2, {7'd0, s2});
        prog[6][4] = enc_r(F7_ALT, F3_ADD, 5'd1, 5'd4, 5'd5);
        expect_x1[6] = (vu << s1) - (vu >> s2);

        // x0 stays zero
        a = 12'(rand_bits(12));
        prog[7][0] = enc_i(F3_ADD, 5'd0, 5'd0, a);
        prog[7][1] = enc_r(7'd0, F3_ADD, 5'd1, 5'd0, 5'd0);
        prog[7][2] = enc_i(F3_ADD, 5'd1, 5'd1, 12'd3);
        expect_x1[7] = 32'd3;

        // Unsupported opcode with rd = x1 in between
        a = 12'(rand_bits(12));
        b = 12'(rand_bits(12));
        prog[8][0] = enc_i(F3_ADD, 5'd1, 5'd0, a);
        prog[8][1] = 32'h0000_00ff;
        prog[8][2] = enc_i(F3_ADD, 5'd1, 5'd1, b);
        expect_x1[8] = sext12(a) + sext12(b);

        // Whole RAM to no-ops so fetch past the program stays harmless
        for (int i = 0; i < 2**IMEM_AW; i++) begin
            write_word(i, 32'h0);
        end

        for (int t = 0; t < NTESTS && !hung; t++) begin
            @(negedge clk);
            rst = 1'b1;
            for (int i = 0; i < LOAD_LEN; i++) begin
                write_word(i, (i < PROG_LEN) ? prog[t][i] : 32'h0);
            end
            @(negedge clk);
            prog_we    = 1'b0;
            rst        = 1'b0;
            exp_x1     = expect_x1[t];
            budget_now = budget[t];
            start      = 1'b1;
            @(negedge clk);
            n = 0;
            while (!done && n < DONE_MAX) begin
                @(negedge clk);
                n++;
            end
            if (!done) begin
                $display("test %0d: checker gave no result in %0d cycles", t, DONE_MAX);
                hung = 1'b1;
            end
            start = 1'b0;
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !hung) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/core_pkg.sv
hdl/instr_ram.sv
hdl/decode.sv
hdl/regfile.sv
hdl/exec.sv
hdl/core.sv
tb/core_checker.sv
tb/tb_core.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the core testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_core -f flist.f -o tb_core_sim \
    && ./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Testbench passed$" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
